//--- logic/mlu_settings.svh
`ifndef MLU_SETTINGS_SVH
`define MLU_SETTINGS_SVH

// Number of 4-bit slices in one word
`define MLU_SLICES 4

// Word width follows from the slice count
`define MLU_WIDTH (4 * `MLU_SLICES)

// AXI4-Lite bus
`define MLU_AXI_ADDR_W 4
`define MLU_AXI_DATA_W 32

`endif

//--- logic/mlu_pkg.sv
`include "mlu_settings.svh"

package mlu_pkg;

  // Slice operation codes, also the CONTROL op field
  typedef enum logic [2:0] {
    MLU_ADD  = 3'd0,
    MLU_SUB  = 3'd1,  // A + ~B + carry
    MLU_AND  = 3'd2,
    MLU_OR   = 3'd3,
    MLU_XOR  = 3'd4,
    MLU_NOT  = 3'd5,  // Only A is used
    MLU_ANOT = 3'd6,  // A and not B
    MLU_NOP  = 3'd7
  } mlu_op_e;

  // Slice output byte, seen as a table word or as flag fields
  typedef union packed {
    logic [7:0] raw;
    struct packed {
      logic       spare;   // Always 0
      logic       zero;    // Nibble is 0
      logic       gen;     // Carry generate
      logic       prop;    // Carry propagate
      logic [3:0] nibble;
    } flags;
  } mlu_slice_out_u;

  // Register map
  localparam logic [`MLU_AXI_ADDR_W-1:0] MLU_REG_A      = 'h0;
  localparam logic [`MLU_AXI_ADDR_W-1:0] MLU_REG_B      = 'h4;
  localparam logic [`MLU_AXI_ADDR_W-1:0] MLU_REG_CTRL   = 'h8;
  localparam logic [`MLU_AXI_ADDR_W-1:0] MLU_REG_RESULT = 'hC;

  localparam int MLU_CTRL_CIN_BIT  = 3;   // CONTROL carry_in
  localparam int MLU_RES_CARRY_BIT = 16;  // RESULT carry flag
  localparam int MLU_RES_ZERO_BIT  = 17;  // RESULT zero flag

  localparam logic [1:0] MLU_RESP_OKAY = 2'b00;

endpackage

//--- logic/mlu_slice.sv
`timescale 1ns/100ps

module mlu_slice (
  input  logic [11:0]                addr,
  output mlu_pkg::mlu_slice_out_u    out
);
  import mlu_pkg::*;

  logic [3:0] a;
  logic [3:0] b;
  mlu_op_e    op;
  logic       c_in;

  logic [3:0] b_eff;   // B, inverted for subtract
  logic [4:0] sum5;    // A + B_eff without carry-in
  logic [3:0] nib;
  logic       prop;
  logic       gen;

  // Address word, top to bottom: carry-in, op, B, A
  assign a    = addr[3:0];
  assign b    = addr[7:4];
  assign op   = mlu_op_e'(addr[10:8]);
  assign c_in = addr[11];

  assign b_eff = (op == MLU_SUB) ? ~b : b;
  assign sum5  = {1'b0, a} + {1'b0, b_eff};

  always_comb begin
    prop = 1'b0;
    gen  = 1'b0;
    case (op)
      MLU_ADD, MLU_SUB: begin
        nib  = a + b_eff + {3'b0, c_in};
        prop = (sum5[3:0] == 4'hF);  // Passes an incoming carry on
        gen  = sum5[4];              // Carries out by itself
      end
      MLU_AND:  nib = a & b;
      MLU_OR:   nib = a | b;
      MLU_XOR:  nib = a ^ b;
      MLU_NOT:  nib = ~a;
      MLU_ANOT: nib = a & ~b;
      default:  nib = 4'h0;  // NOP
    endcase
  end

  // Packed the same way as a table entry
  assign out.raw = {1'b0, nib == 4'h0, gen, prop, nib};

endmodule

//--- logic/mlu_carry_chain.sv
`timescale 1ns/100ps

module mlu_carry_chain (
  input  logic       carry_in,
  input  logic [3:0] prop,
  input  logic [3:0] gen,
  output logic [3:0] slice_carry,
  output logic       carry_out
);

  logic [3:0] p;
  logic [3:0] g;

  assign p = prop;
  assign g = gen;

  // Every carry is expanded down to carry_in, so none waits on the one below
  assign slice_carry[0] = carry_in;

  assign slice_carry[1] = g[0]
                        | (p[0] & carry_in);

  assign slice_carry[2] = g[1]
                        | (p[1] & g[0])
                        | (p[1] & p[0] & carry_in);

  assign slice_carry[3] = g[2]
                        | (p[2] & g[1])
                        | (p[2] & p[1] & g[0])
                        | (p[2] & p[1] & p[0] & carry_in);

  // One step past the top slice
  assign carry_out = g[3]
                   | (p[3] & g[2])
                   | (p[3] & p[2] & g[1])
                   | (p[3] & p[2] & p[1] & g[0])
                   | (p[3] & p[2] & p[1] & p[0] & carry_in);

endmodule

//--- logic/mlu_word.sv
`timescale 1ns/100ps
`include "mlu_settings.svh"

module mlu_word (
  input  logic [`MLU_WIDTH-1:0] operand_a,
  input  logic [`MLU_WIDTH-1:0] operand_b,
  input  mlu_pkg::mlu_op_e      op,
  input  logic                  carry_in,
  output logic [`MLU_WIDTH-1:0] result,
  output logic                  carry_out,
  output logic                  zero
);
  import mlu_pkg::*;

  logic [11:0]           slice_addr [`MLU_SLICES];
  mlu_slice_out_u        slice_out  [`MLU_SLICES];
  logic [`MLU_SLICES-1:0] slice_carry;
  logic [`MLU_SLICES-1:0] slice_prop;
  logic [`MLU_SLICES-1:0] slice_gen;
  logic [`MLU_SLICES-1:0] slice_zero;

  for (genvar i = 0; i < `MLU_SLICES; i++) begin : g_slice
    // Carry from the lookahead network, not from the slice below
    assign slice_addr[i] = {slice_carry[i], op, operand_b[4*i +: 4], operand_a[4*i +: 4]};

    mlu_slice u_slice (
      .addr (slice_addr[i]),
      .out  (slice_out[i])
    );

    assign result[4*i +: 4] = slice_out[i].flags.nibble;
    assign slice_prop[i]    = slice_out[i].flags.prop;
    assign slice_gen[i]     = slice_out[i].flags.gen;
    assign slice_zero[i]    = slice_out[i].flags.zero;
  end

  mlu_carry_chain u_chain (
    .carry_in    (carry_in),
    .prop        (slice_prop),
    .gen         (slice_gen),
    .slice_carry (slice_carry),
    .carry_out   (carry_out)
  );

  assign zero = &slice_zero;  // All nibbles zero

endmodule

//--- logic/mlu_regs.sv
`timescale 1ns/100ps
`include "mlu_settings.svh"

module mlu_regs (
  input  logic                         clk,
  input  logic                         rst_n,
  // Write address and data
  input  logic                         awvalid,
  output logic                         awready,
  input  logic [`MLU_AXI_ADDR_W-1:0]   awaddr,
  input  logic                         wvalid,
  output logic                         wready,
  input  logic [`MLU_AXI_DATA_W-1:0]   wdata,
  input  logic [`MLU_AXI_DATA_W/8-1:0] wstrb,
  // Write response
  output logic                         bvalid,
  input  logic                         bready,
  output logic [1:0]                   bresp,
  // Read
  input  logic                         arvalid,
  output logic                         arready,
  input  logic [`MLU_AXI_ADDR_W-1:0]   araddr,
  output logic                         rvalid,
  input  logic                         rready,
  output logic [`MLU_AXI_DATA_W-1:0]   rdata,
  output logic [1:0]                   rresp,
  // To and from the word unit
  output logic [`MLU_WIDTH-1:0]        operand_a,
  output logic [`MLU_WIDTH-1:0]        operand_b,
  output mlu_pkg::mlu_op_e             op,
  output logic                         carry_in,
  input  logic [`MLU_WIDTH-1:0]        result,
  input  logic                         carry_out,
  input  logic                         zero
);
  import mlu_pkg::*;

  logic                       wr_start;
  logic                       wr_fire;
  logic                       rd_fire;
  logic [`MLU_AXI_DATA_W-1:0] rd_word;

  // Address and data taken together, only while no response is pending
  assign wr_start = awvalid && wvalid && !awready && !bvalid;
  assign wr_fire  = awvalid && awready && wvalid && wready;
  assign rd_fire  = arvalid && arready;

  assign bresp = MLU_RESP_OKAY;
  assign rresp = MLU_RESP_OKAY;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
    end else begin
      awready <= wr_start;  // One-cycle pulse
      wready  <= wr_start;
      if (wr_fire) begin
        bvalid <= 1'b1;
      end else if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  // Writable registers, byte strobes honoured
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      operand_a <= '0;
      operand_b <= '0;
      op        <= MLU_ADD;
      carry_in  <= 1'b0;
    end else if (wr_fire) begin
      case (awaddr)
        MLU_REG_A: begin
          for (int i = 0; i < `MLU_WIDTH / 8; i++) begin
            if (wstrb[i]) operand_a[8*i +: 8] <= wdata[8*i +: 8];
          end
        end
        MLU_REG_B: begin
          for (int i = 0; i < `MLU_WIDTH / 8; i++) begin
            if (wstrb[i]) operand_b[8*i +: 8] <= wdata[8*i +: 8];
          end
        end
        MLU_REG_CTRL: begin
          if (wstrb[0]) begin  // Both fields live in byte 0
            op       <= mlu_op_e'(wdata[2:0]);
            carry_in <= wdata[MLU_CTRL_CIN_BIT];
          end
        end
        default: ;  // RESULT and holes are not writable
      endcase
    end
  end

  // Read mux, RESULT comes straight from the datapath
  always_comb begin
    rd_word = '0;
    case (araddr)
      MLU_REG_A:    rd_word[`MLU_WIDTH-1:0] = operand_a;
      MLU_REG_B:    rd_word[`MLU_WIDTH-1:0] = operand_b;
      MLU_REG_CTRL: begin
        rd_word[2:0]             = op;
        rd_word[MLU_CTRL_CIN_BIT] = carry_in;
      end
      MLU_REG_RESULT: begin
        rd_word[`MLU_WIDTH-1:0]    = result;
        rd_word[MLU_RES_CARRY_BIT] = carry_out;
        rd_word[MLU_RES_ZERO_BIT]  = zero;
      end
      default: ;  // Unmapped reads give 0
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      arready <= 1'b1;
      rvalid  <= 1'b0;
    end else if (rd_fire) begin
      arready <= 1'b0;  // Hold off until data is taken
      rvalid  <= 1'b1;
    end else if (rvalid && rready) begin
      arready <= 1'b1;
      rvalid  <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) rdata <= rd_word;  // Stable while rvalid waits
  end

endmodule

//--- logic/mlu_top.sv
`timescale 1ns/100ps
`include "mlu_settings.svh"

module mlu_top (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         awvalid,
  output logic                         awready,
  input  logic [`MLU_AXI_ADDR_W-1:0]   awaddr,
  input  logic                         wvalid,
  output logic                         wready,
  input  logic [`MLU_AXI_DATA_W-1:0]   wdata,
  input  logic [`MLU_AXI_DATA_W/8-1:0] wstrb,
  output logic                         bvalid,
  input  logic                         bready,
  output logic [1:0]                   bresp,
  input  logic                         arvalid,
  output logic                         arready,
  input  logic [`MLU_AXI_ADDR_W-1:0]   araddr,
  output logic                         rvalid,
  input  logic                         rready,
  output logic [`MLU_AXI_DATA_W-1:0]   rdata,
  output logic [1:0]                   rresp
);
  import mlu_pkg::*;

  logic [`MLU_WIDTH-1:0] operand_a;
  logic [`MLU_WIDTH-1:0] operand_b;
  mlu_op_e               op;
  logic                  carry_in;
  logic [`MLU_WIDTH-1:0] result;
  logic                  carry_out;
  logic                  zero;

  mlu_regs u_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .awvalid   (awvalid),
    .awready   (awready),
    .awaddr    (awaddr),
    .wvalid    (wvalid),
    .wready    (wready),
    .wdata     (wdata),
    .wstrb     (wstrb),
    .bvalid    (bvalid),
    .bready    (bready),
    .bresp     (bresp),
    .arvalid   (arvalid),
    .arready   (arready),
    .araddr    (araddr),
    .rvalid    (rvalid),
    .rready    (rready),
    .rdata     (rdata),
    .rresp     (rresp),
    .operand_a (operand_a),
    .operand_b (operand_b),
    .op        (op),
    .carry_in  (carry_in),
    .result    (result),
    .carry_out (carry_out),
    .zero      (zero)
  );

  // Purely combinational datapath
  mlu_word u_word (
    .operand_a (operand_a),
    .operand_b (operand_b),
    .op        (op),
    .carry_in  (carry_in),
    .result    (result),
    .carry_out (carry_out),
    .zero      (zero)
  );

endmodule

//--- testbench/mlu_clock_gen.sv
`timescale 1ns/100ps

module mlu_clock_gen (
  output logic clk,
  output logic rst_n
);

  localparam int HALF_PERIOD_NS = 4;  // 8 ns clock
  localparam int RESET_CYCLES   = 16;

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD_NS) clk = ~clk;
  end

  // Released on a falling edge like every other DUT input
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

//--- testbench/mlu_asserts.sv
`timescale 1ns/100ps
`include "mlu_settings.svh"

module mlu_asserts (
  input logic                       clk,
  input logic                       rst_n,
  input logic                       bvalid,
  input logic                       bready,
  input logic [1:0]                 bresp,
  input logic                       rvalid,
  input logic                       rready,
  input logic [`MLU_AXI_DATA_W-1:0] rdata,
  input logic [1:0]                 rresp
);
  import mlu_pkg::*;

  int fail_count = 0;  // Read by the testbench at the end

  bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid && !bready |=> bvalid)
    else begin
      fail_count++;
      $error("bvalid dropped before bready");
    end

  rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid && !rready |=> rvalid)
    else begin
      fail_count++;
      $error("rvalid dropped before rready");
    end

  // Read data must not move while the host stalls
  rdata_stable: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid && !rready |=> $stable(rdata))
    else begin
      fail_count++;
      $error("rdata changed while rvalid waited");
    end

  resp_okay: assert property (@(posedge clk) disable iff (!rst_n)
    bresp == MLU_RESP_OKAY && rresp == MLU_RESP_OKAY)
    else begin
      fail_count++;
      $error("bresp or rresp is not OKAY");
    end

  bvalid_reset: assert property (@(posedge clk) !rst_n |=> !bvalid)
    else begin
      fail_count++;
      $error("bvalid high during reset");
    end

endmodule

bind mlu_regs mlu_asserts u_asserts (
  .clk    (clk),
  .rst_n  (rst_n),
  .bvalid (bvalid),
  .bready (bready),
  .bresp  (bresp),
  .rvalid (rvalid),
  .rready (rready),
  .rdata  (rdata),
  .rresp  (rresp)
);

//--- testbench/mlu_tb.sv
`timescale 1ns/100ps
`include "mlu_settings.svh"

module mlu_tb;
  import mlu_pkg::*;

  localparam int NUM_ARITH   = 200;
  localparam int NUM_LOGIC   = 8;  // Per logic op and NOP
  localparam int NUM_XFERS   = 4 * (NUM_ARITH + 7 + 6 * NUM_LOGIC) + 60;
  localparam int WATCHDOG_NS = (NUM_XFERS * 40 + 16) * 8;
  localparam int HS_LIMIT    = 32;  // Cycles to wait on one handshake

  logic                         clk;
  logic                         rst_n;
  logic                         awvalid;
  logic                         awready;
  logic [`MLU_AXI_ADDR_W-1:0]   awaddr;
  logic                         wvalid;
  logic                         wready;
  logic [`MLU_AXI_DATA_W-1:0]   wdata;
  logic [`MLU_AXI_DATA_W/8-1:0] wstrb;
  logic                         bvalid;
  logic                         bready;
  logic [1:0]                   bresp;
  logic                         arvalid;
  logic                         arready;
  logic [`MLU_AXI_ADDR_W-1:0]   araddr;
  logic                         rvalid;
  logic                         rready;
  logic [`MLU_AXI_DATA_W-1:0]   rdata;
  logic [1:0]                   rresp;

  logic [31:0] lcg_state = 32'd10947;
  int          mismatch_count = 0;
  int          fail_count = 0;
  string       name_q[$];
  logic [31:0] exp_q[$];
  logic [31:0] act_q[$];

  mlu_clock_gen clock0 (
    .clk   (clk),
    .rst_n (rst_n)
  );

  mlu_top dut0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .awvalid (awvalid),
    .awready (awready),
    .awaddr  (awaddr),
    .wvalid  (wvalid),
    .wready  (wready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .bvalid  (bvalid),
    .bready  (bready),
    .bresp   (bresp),
    .arvalid (arvalid),
    .arready (arready),
    .araddr  (araddr),
    .rvalid  (rvalid),
    .rready  (rready),
    .rdata   (rdata),
    .rresp   (rresp)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic logic [15:0] random_half();
    logic [31:0] s;
    s = lcg_next();
    return s[31:16];  // Upper bits are the better ones
  endfunction

  // Expected RESULT word: zero in bit 17, carry in bit 16
  function automatic logic [31:0] expect_result(input logic [15:0] a, input logic [15:0] b,
                                                input mlu_op_e op, input logic cin);
    logic [16:0] sum;
    logic [15:0] r;
    logic        carry;
    sum   = '0;
    carry = 1'b0;
    case (op)
      MLU_ADD:  sum = {1'b0, a} + {1'b0, b} + {16'b0, cin};
      MLU_SUB:  sum = {1'b0, a} + {1'b0, ~b} + {16'b0, cin};
      default:  sum = '0;
    endcase
    case (op)
      MLU_ADD, MLU_SUB: begin
        r     = sum[15:0];
        carry = sum[16];
      end
      MLU_AND:  r = a & b;
      MLU_OR:   r = a | b;
      MLU_XOR:  r = a ^ b;
      MLU_NOT:  r = ~a;
      MLU_ANOT: r = a & ~b;
      default:  r = 16'h0;
    endcase
    return {14'b0, r == 16'h0, carry, r};
  endfunction

  task automatic write_request(input logic [`MLU_AXI_ADDR_W-1:0] addr,
                               input logic [31:0] data, input logic [3:0] strb);
    int n;
    n       = 0;
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    while (!(awready && wready) && n < HS_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!(awready && wready)) begin
      fail_count++;
      $display("write to offset %h was never accepted", addr);
    end else begin
      @(negedge clk);  // Transfer on the rising edge in between
    end
    awvalid = 1'b0;
    wvalid  = 1'b0;
  endtask

  task automatic write_response();
    int n;
    n = 0;
    while (!(bvalid && bready) && n < HS_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!(bvalid && bready)) begin
      fail_count++;
      $display("write response never arrived");
    end else begin
      @(negedge clk);
    end
  endtask

  task automatic axi_write(input logic [`MLU_AXI_ADDR_W-1:0] addr,
                           input logic [31:0] data, input logic [3:0] strb);
    write_request(addr, data, strb);
    write_response();
  endtask

  task automatic read_request(input logic [`MLU_AXI_ADDR_W-1:0] addr);
    int n;
    n       = 0;
    araddr  = addr;
    arvalid = 1'b1;
    while (!arready && n < HS_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!arready) begin
      fail_count++;
      $display("read of offset %h was never accepted", addr);
    end else begin
      @(negedge clk);
    end
    arvalid = 1'b0;
  endtask

  task automatic read_response(output logic [31:0] data);
    int n;
    n    = 0;
    data = '0;
    while (!(rvalid && rready) && n < HS_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!(rvalid && rready)) begin
      fail_count++;
      $display("read data never arrived");
    end else begin
      data = rdata;
      @(negedge clk);
    end
  endtask

  task automatic axi_read(input logic [`MLU_AXI_ADDR_W-1:0] addr, output logic [31:0] data);
    read_request(addr);
    read_response(data);
  endtask

  task automatic push_check(input string name, input logic [31:0] exp_val,
                            input logic [31:0] act_val);
    name_q.push_back(name);
    exp_q.push_back(exp_val);
    act_q.push_back(act_val);
  endtask

  task automatic check_read(input string name, input logic [`MLU_AXI_ADDR_W-1:0] addr,
                            input logic [31:0] exp_val);
    logic [31:0] data;
    axi_read(addr, data);
    push_check(name, exp_val, data);
  endtask

  // Loads operands and control, then reads RESULT
  task automatic run_op(input string name, input logic [15:0] a, input logic [15:0] b,
                        input mlu_op_e op, input logic cin);
    axi_write(MLU_REG_A, {16'h0, a}, 4'hF);
    axi_write(MLU_REG_B, {16'h0, b}, 4'hF);
    axi_write(MLU_REG_CTRL, {28'h0, cin, op}, 4'h1);
    check_read(name, MLU_REG_RESULT, expect_result(a, b, op, cin));
  endtask

  always @(posedge clk) begin : compare
    string       name;
    logic [31:0] exp_val;
    logic [31:0] act_val;
    while (act_q.size() != 0) begin
      name    = name_q.pop_front();
      exp_val = exp_q.pop_front();
      act_val = act_q.pop_front();
      if (act_val !== exp_val) begin
        mismatch_count++;
        $display("mismatch %s: expected %08h, actual %08h", name, exp_val, act_val);
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("timeout after %0d ns, the tests did not finish", WATCHDOG_NS);
    $display("TB FAILED");
    $finish;
  end

  initial begin : stimulus
    logic [31:0] data;
    logic [31:0] held;
    logic [31:0] r;
    logic [15:0] a;
    logic [15:0] b;
    mlu_op_e     op;
    logic        cin;
    int          assert_fails;
    awvalid = 1'b0;
    awaddr  = '0;
    wvalid  = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    bready  = 1'b1;
    arvalid = 1'b0;
    araddr  = '0;
    rready  = 1'b1;
    @(posedge rst_n);
    @(negedge clk);

    check_read("reset operand_a", MLU_REG_A, 32'h0);
    check_read("reset operand_b", MLU_REG_B, 32'h0);
    check_read("reset control", MLU_REG_CTRL, 32'h0);
    check_read("reset result", MLU_REG_RESULT, expect_result(16'h0, 16'h0, MLU_ADD, 1'b0));

    // Carries that ripple through every slice
    run_op("add ffff+1", 16'hFFFF, 16'h0001, MLU_ADD, 1'b0);
    run_op("add ffff+0+cin", 16'hFFFF, 16'h0000, MLU_ADD, 1'b1);
    run_op("add ffff+ffff+cin", 16'hFFFF, 16'hFFFF, MLU_ADD, 1'b1);
    run_op("sub 0-1", 16'h0000, 16'h0001, MLU_SUB, 1'b1);
    run_op("sub 0-0", 16'h0000, 16'h0000, MLU_SUB, 1'b1);
    run_op("sub 0-0 no cin", 16'h0000, 16'h0000, MLU_SUB, 1'b0);

    for (int i = 0; i < NUM_ARITH; i++) begin
      a   = random_half();
      b   = random_half();
      r   = lcg_next();
      op  = r[20] ? MLU_SUB : MLU_ADD;
      cin = r[21];
      run_op($sformatf("random %s %0d", op.name(), i), a, b, op, cin);
    end

    for (int k = 2; k < 8; k++) begin
      for (int i = 0; i < NUM_LOGIC; i++) begin
        a   = random_half();
        b   = random_half();
        r   = lcg_next();
        op  = mlu_op_e'(k);
        cin = r[21];  // Must not matter here
        run_op($sformatf("logic %s %0d", op.name(), i), a, b, op, cin);
      end
    end
    run_op("xor equal operands", 16'h5A5A, 16'h5A5A, MLU_XOR, 1'b1);

    // Byte strobes
    axi_write(MLU_REG_A, 32'hFFFF_1234, 4'hF);
    check_read("operand_a full word", MLU_REG_A, 32'h0000_1234);
    axi_write(MLU_REG_A, 32'h0000_AB00, 4'h2);
    check_read("operand_a byte 1", MLU_REG_A, 32'h0000_AB34);
    axi_write(MLU_REG_B, 32'h0000_CAFE, 4'hF);
    axi_write(MLU_REG_B, 32'h0000_7711, 4'h1);
    check_read("operand_b byte 0", MLU_REG_B, 32'h0000_CA11);
    axi_write(MLU_REG_CTRL, 32'h0000_000C, 4'h1);
    check_read("control xor with cin", MLU_REG_CTRL, 32'h0000_000C);
    axi_write(MLU_REG_CTRL, 32'h0000_0F03, 4'h2);
    check_read("control unstrobed byte", MLU_REG_CTRL, 32'h0000_000C);

    // Read-only RESULT and holes in the map
    axi_write(MLU_REG_RESULT, 32'hFFFF_FFFF, 4'hF);
    axi_write(4'h2, 32'hFFFF_FFFF, 4'hF);
    axi_write(4'h7, 32'hFFFF_FFFF, 4'hF);
    check_read("operand_a kept", MLU_REG_A, 32'h0000_AB34);
    check_read("operand_b kept", MLU_REG_B, 32'h0000_CA11);
    check_read("control kept", MLU_REG_CTRL, 32'h0000_000C);
    check_read("result kept", MLU_REG_RESULT,
               expect_result(16'hAB34, 16'hCA11, MLU_XOR, 1'b1));
    check_read("unmapped 0x2", 4'h2, 32'h0);
    check_read("unmapped 0xd", 4'hD, 32'h0);

    // Host stalls the write response
    bready = 1'b0;
    write_request(MLU_REG_A, 32'h0000_8001, 4'hF);
    repeat (6) begin
      @(negedge clk);
      if (!bvalid) begin
        fail_count++;
        $display("bvalid fell while bready was held low");
      end
    end
    bready = 1'b1;
    write_response();

    // Host stalls the read data
    rready = 1'b0;
    read_request(MLU_REG_A);
    held = rdata;
    repeat (6) begin
      @(negedge clk);
      if (!rvalid || rdata !== held) begin
        fail_count++;
        $display("rvalid or rdata changed while rready was held low");
      end
    end
    rready = 1'b1;
    read_response(data);
    push_check("rdata during stall", 32'h0000_8001, held);
    push_check("read after stall", 32'h0000_8001, data);
    run_op("add after stall", 16'h0FFF, 16'h0001, MLU_ADD, 1'b0);

    repeat (2) @(posedge clk);  // Let the compare process drain
    @(negedge clk);
    assert_fails = dut0.u_regs.u_asserts.fail_count;
    $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
             mismatch_count, fail_count, assert_fails);
    if (mismatch_count == 0 && fail_count == 0 && assert_fails == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- sim.f
+incdir+logic
logic/mlu_pkg.sv
logic/mlu_slice.sv
logic/mlu_carry_chain.sv
logic/mlu_word.sv
logic/mlu_regs.sv
logic/mlu_top.sv
testbench/mlu_clock_gen.sv
testbench/mlu_asserts.sv
testbench/mlu_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f sim.f --top-module mlu_tb --Mdir obj_dir -o mlu_sim

# Keep running past assertion errors so the testbench prints its verdict
./obj_dir/mlu_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -qx "TB PASSED" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
